// File: Makefile
# Verilator simulation of the CQ receiver

VERILATOR ?= verilator
TOP       ?= tb_cq_rx
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: cpl_req_gen.sv
module cpl_req_gen (
  input  logic                 user_clk,
  input  logic                 user_reset_n,
  input  cq_rx_pkg::cq_desc_t  desc,
  input  logic                 rd_valid,
  output cq_rx_pkg::cpl_req_t  cpl,
  output logic                 cpl_valid
);

  // --------------------------------------------------------------------------
  // Byte enable position helpers
  // --------------------------------------------------------------------------
  function automatic logic [1:0] low_idx(input logic [3:0] v);
    logic [1:0] idx;
    casez (v)
      4'b???1: idx = 2'd0;
      4'b??10: idx = 2'd1;
      4'b?100: idx = 2'd2;
      4'b1000: idx = 2'd3;
      default: idx = 2'd0;                         // No enables set
    endcase
    return idx;
  endfunction

  function automatic logic [1:0] high_idx(input logic [3:0] v);
    logic [1:0] idx;
    casez (v)
      4'b1???: idx = 2'd3;
      4'b01??: idx = 2'd2;
      4'b001?: idx = 2'd1;
      default: idx = 2'd0;
    endcase
    return idx;
  endfunction

  logic [3:0]  first_be;
  logic [3:0]  last_be;
  logic [1:0]  fb_lo;
  logic [1:0]  fb_hi;
  logic [1:0]  lb_hi;
  logic [12:0] bc_wide;                            // Up to 1024 DW times 4
  logic [11:0] byte_count;
  logic [6:0]  lower_addr;

  assign first_be = desc.be[3:0];
  assign last_be  = desc.be[7:4];
  assign fb_lo    = low_idx(first_be);
  assign fb_hi    = high_idx(first_be);
  assign lb_hi    = high_idx(last_be);

  always_comb begin
    if (last_be == 4'h0) begin                     // Single DW request
      if (first_be == 4'h0) begin
        bc_wide = 13'd1;
      end else begin
        bc_wide = 13'(fb_hi) - 13'(fb_lo) + 13'd1;
      end
    end else begin
      bc_wide = {desc.hi.mem.dword_count, 2'b00}
              - 13'(fb_lo)
              - 13'(2'd3 - lb_hi);
    end
  end

  assign byte_count = bc_wide[11:0];               // 4096 wraps to 0
  assign lower_addr = (desc.hi.mem.dword_count == 11'd0) ? 7'd0
                                                         : {desc.lo[6:2], fb_lo};

  // --------------------------------------------------------------------------
  // Completion request register
  // --------------------------------------------------------------------------
  always_ff @(posedge user_clk or negedge user_reset_n) begin
    if (!user_reset_n) begin
      cpl_valid <= 1'b0;
    end else begin
      cpl_valid <= rd_valid;
    end
  end

  always_ff @(posedge user_clk) begin
    if (rd_valid) begin
      cpl.requester_id <= desc.hi.mem.requester_id;
      cpl.tag          <= desc.hi.mem.tag;
      cpl.tc           <= desc.hi.mem.tc;
      cpl.attr         <= desc.hi.mem.attr;
      cpl.dword_count  <= desc.hi.mem.dword_count;
      cpl.byte_count   <= byte_count;
      cpl.lower_addr   <= lower_addr;
    end
  end

endmodule

// File: cq_rx_ctrl.sv
module cq_rx_ctrl (
  input  logic                           user_clk,
  input  logic                           user_reset_n,
  input  logic                           link_up,
  input  logic [cq_rx_pkg::DATA_W-1:0]   cq_tdata,
  input  logic [cq_rx_pkg::TUSER_W-1:0]  cq_tuser,
  input  logic                           cq_tlast,
  input  logic                           cq_tvalid,
  output logic                           cq_tready,
  output cq_rx_pkg::cq_desc_t            desc,
  output logic                           desc_valid,
  output logic                           rd_valid
);

  cq_rx_pkg::cq_state_e         state;
  logic                         beat1_pending;   // Next accepted beat is beat 1
  logic [cq_rx_pkg::DATA_W-1:0] lo_q;            // Beat 0 holding register
  logic [cq_rx_pkg::BE_W-1:0]   be_q;
  logic                         accept;
  logic                         sop;
  cq_rx_pkg::cq_desc_hi_u       beat1;
  cq_rx_pkg::req_kind_e         kind_dec;
  logic                         kind_ok;

  assign accept = cq_tvalid & cq_tready;
  assign sop    = cq_tuser[cq_rx_pkg::TUSER_SOP];
  assign beat1  = cq_tdata;

  // --------------------------------------------------------------------------
  // Request type decode on the live beat
  // --------------------------------------------------------------------------
  always_comb begin
    kind_ok  = 1'b1;
    kind_dec = cq_rx_pkg::kind_msg;
    case (beat1.mem.req_type)
      cq_rx_pkg::REQ_MEM_RD: kind_dec = cq_rx_pkg::kind_mem_rd;
      cq_rx_pkg::REQ_MEM_WR: kind_dec = cq_rx_pkg::kind_mem_wr;
      cq_rx_pkg::REQ_VDM:    kind_dec = cq_rx_pkg::kind_vdm;
      cq_rx_pkg::REQ_MSG,
      cq_rx_pkg::REQ_ATS:    kind_dec = cq_rx_pkg::kind_msg;
      default:               kind_ok  = 1'b0;         // Not handled here
    endcase
  end

  // --------------------------------------------------------------------------
  // Link and frame FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge user_clk or negedge user_reset_n) begin
    if (!user_reset_n) begin
      state         <= cq_rx_pkg::st_reset;
      cq_tready     <= 1'b0;
      beat1_pending <= 1'b0;
      desc_valid    <= 1'b0;
      rd_valid      <= 1'b0;
    end else begin
      desc_valid <= 1'b0;                              // Single cycle strobes
      rd_valid   <= 1'b0;
      case (state)
        cq_rx_pkg::st_reset: begin
          cq_tready <= 1'b0;
          state     <= cq_rx_pkg::st_down;
        end
        cq_rx_pkg::st_down: begin
          cq_tready     <= link_up;
          beat1_pending <= 1'b0;
          if (link_up) begin
            state <= cq_rx_pkg::st_idle;
          end
        end
        cq_rx_pkg::st_idle: begin
          if (!link_up) begin
            cq_tready <= 1'b0;
            state     <= cq_rx_pkg::st_down;
          end else if (accept && sop) begin
            beat1_pending <= 1'b1;
            state         <= cq_rx_pkg::st_active;
          end
        end
        cq_rx_pkg::st_active: begin
          if (!link_up) begin
            cq_tready     <= 1'b0;                     // Partial packet is lost
            beat1_pending <= 1'b0;
            state         <= cq_rx_pkg::st_down;
          end else if (accept) begin
            beat1_pending <= 1'b0;
            if (beat1_pending && kind_ok) begin
              desc_valid <= 1'b1;
              rd_valid   <= (kind_dec == cq_rx_pkg::kind_mem_rd);
            end
            if (cq_tlast) begin
              state <= cq_rx_pkg::st_idle;
            end
          end
        end
        default: begin
          cq_tready <= 1'b0;
          state     <= cq_rx_pkg::st_down;
        end
      endcase
    end
  end

  // Descriptor capture
  always_ff @(posedge user_clk) begin
    if ((state == cq_rx_pkg::st_idle) && accept && sop) begin
      lo_q <= cq_tdata;
      be_q <= cq_tuser[cq_rx_pkg::BE_W-1:0];
    end
    if ((state == cq_rx_pkg::st_active) && accept && beat1_pending) begin
      desc.lo   <= lo_q;
      desc.be   <= be_q;
      desc.hi   <= beat1;
      desc.kind <= kind_dec;
    end
  end

endmodule

// File: cq_rx_pkg.sv
package cq_rx_pkg;

  // --------------------------------------------------------------------------
  // Stream geometry
  // --------------------------------------------------------------------------
  localparam int DATA_W    = 64;                 // CQ data width
  localparam int BE_W      = 8;                  // {last DW BE, first DW BE}
  localparam int KEEP_W    = DATA_W / 32;        // One keep bit per DW
  localparam int TUSER_W   = 41;                 // Through start-of-packet bit
  localparam int TUSER_SOP = 40;                 // Start of packet in tuser

  // Request type codes found in descriptor bits 78:75 (beat 1 bits 14:11)
  localparam logic [3:0] REQ_MEM_RD = 4'b0000;
  localparam logic [3:0] REQ_MEM_WR = 4'b0001;
  localparam logic [3:0] REQ_MSG    = 4'b1100;
  localparam logic [3:0] REQ_VDM    = 4'b1101;
  localparam logic [3:0] REQ_ATS    = 4'b1110;

  typedef enum logic [1:0] {
    kind_mem_rd,
    kind_mem_wr,
    kind_vdm,
    kind_msg                                     // ATS and other messages
  } req_kind_e;

  // --------------------------------------------------------------------------
  // Two views of descriptor beat 1
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic        rsvd_63;
    logic [2:0]  attr;                           // IDO, RO, NS
    logic [2:0]  tc;
    logic [16:0] bar_func;                       // BAR and target function
    logic [7:0]  tag;
    logic [15:0] requester_id;
    logic        rsvd_15;
    logic [3:0]  req_type;
    logic [10:0] dword_count;
  } cq_mem_fields_t;

  typedef struct packed {
    logic        rsvd_63;
    logic [2:0]  attr;
    logic [2:0]  tc;
    logic [5:0]  spare;
    logic [2:0]  msg_routing;                    // Bits 50:48
    logic [7:0]  msg_code;                       // Bits 47:40
    logic [7:0]  tag;
    logic [15:0] requester_id;
    logic        rsvd_15;
    logic [3:0]  req_type;
    logic [10:0] dword_count;
  } cq_msg_fields_t;

  typedef union packed {
    cq_mem_fields_t mem;
    cq_msg_fields_t msg;
  } cq_desc_hi_u;

  typedef struct packed {
    logic [DATA_W-1:0] lo;                       // Address or message data
    logic [BE_W-1:0]   be;
    cq_desc_hi_u       hi;
    req_kind_e         kind;
  } cq_desc_t;

  // --------------------------------------------------------------------------
  // Results
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [2:0]  fmt;
    logic [4:0]  typ;
    logic        rsvd_0;
    logic [2:0]  tc;
    logic        rsvd_1;
    logic        ido;
    logic [1:0]  tph;
    logic        td;                             // Digest present
    logic        ep;                             // Poisoned
    logic [1:0]  ro_ns;
    logic [1:0]  at;
    logic [9:0]  length;
    logic [15:0] requester_id;
    logic [7:0]  tag;
    logic [7:0]  be_code;                        // Byte enables or message code
    logic [63:0] dw23;                           // Address or message DWs
  } tlp_hdr_t;

  typedef struct packed {
    logic [15:0] requester_id;
    logic [7:0]  tag;
    logic [2:0]  tc;
    logic [2:0]  attr;
    logic [10:0] dword_count;
    logic [11:0] byte_count;
    logic [6:0]  lower_addr;
  } cpl_req_t;

  typedef enum logic [3:0] {
    st_reset  = 4'b0001,
    st_down   = 4'b0010,
    st_idle   = 4'b0100,
    st_active = 4'b1000
  } cq_state_e;

endpackage

// File: cq_rx_top.sv
module cq_rx_top (
  input  logic                           user_clk,
  input  logic                           user_reset_n,
  input  logic                           link_up,
  input  logic [cq_rx_pkg::DATA_W-1:0]   cq_tdata,
  input  logic [cq_rx_pkg::TUSER_W-1:0]  cq_tuser,
  input  logic [cq_rx_pkg::KEEP_W-1:0]   cq_tkeep,   // Payload is discarded
  input  logic                           cq_tlast,
  input  logic                           cq_tvalid,
  output logic                           cq_tready,
  output logic                           hdr_valid,
  output cq_rx_pkg::tlp_hdr_t            hdr,
  output logic                           cpl_valid,
  output cq_rx_pkg::cpl_req_t            cpl
);

  cq_rx_pkg::cq_desc_t desc;
  logic                desc_valid;
  logic                rd_valid;                     // Memory reads only

  cq_rx_ctrl u_cq_rx_ctrl (
    .user_clk     (user_clk),
    .user_reset_n (user_reset_n),
    .link_up      (link_up),
    .cq_tdata     (cq_tdata),
    .cq_tuser     (cq_tuser),
    .cq_tlast     (cq_tlast),
    .cq_tvalid    (cq_tvalid),
    .cq_tready    (cq_tready),
    .desc         (desc),
    .desc_valid   (desc_valid),
    .rd_valid     (rd_valid)
  );

  // Header and completion both land two cycles after beat 1
  cq_tlp_hdr u_cq_tlp_hdr (
    .user_clk     (user_clk),
    .user_reset_n (user_reset_n),
    .desc         (desc),
    .desc_valid   (desc_valid),
    .hdr          (hdr),
    .hdr_valid    (hdr_valid)
  );

  cpl_req_gen u_cpl_req_gen (
    .user_clk     (user_clk),
    .user_reset_n (user_reset_n),
    .desc         (desc),
    .rd_valid     (rd_valid),
    .cpl          (cpl),
    .cpl_valid    (cpl_valid)
  );

endmodule

// File: cq_tlp_hdr.sv
module cq_tlp_hdr (
  input  logic                 user_clk,
  input  logic                 user_reset_n,
  input  cq_rx_pkg::cq_desc_t  desc,
  input  logic                 desc_valid,
  output cq_rx_pkg::tlp_hdr_t  hdr,
  output logic                 hdr_valid
);

  cq_rx_pkg::tlp_hdr_t hdr_next;
  logic                addr_hi_zero;
  logic                is_wr;

  assign addr_hi_zero = (desc.lo[63:32] == 32'h0);
  assign is_wr        = (desc.kind == cq_rx_pkg::kind_mem_wr);

  // --------------------------------------------------------------------------
  // Header layout chosen by the decoded kind
  // --------------------------------------------------------------------------
  always_comb begin
    hdr_next = '0;                                      // Reserved fields stay 0
    case (desc.kind)
      cq_rx_pkg::kind_mem_rd,
      cq_rx_pkg::kind_mem_wr: begin
        hdr_next.fmt          = {1'b0, is_wr, ~addr_hi_zero}; // 3 DW or 4 DW
        hdr_next.typ          = 5'b00000;
        hdr_next.tc           = desc.hi.mem.tc;
        hdr_next.ido          = desc.hi.mem.attr[2];
        hdr_next.ro_ns        = desc.hi.mem.attr[1:0];
        hdr_next.length       = desc.hi.mem.dword_count[9:0];
        hdr_next.requester_id = desc.hi.mem.requester_id;
        hdr_next.tag          = desc.hi.mem.tag;
        hdr_next.be_code      = desc.be;                // Last BE then first BE
        if (addr_hi_zero) begin
          hdr_next.dw23 = {desc.lo[31:2], 2'b00, 32'h0};
        end else begin
          hdr_next.dw23 = {desc.lo[63:2], 2'b00};
        end
      end
      default: begin                                    // VDM, ATS, other messages
        hdr_next.fmt          = 3'b001;
        hdr_next.typ          = {2'b10, desc.hi.msg.msg_routing};
        hdr_next.tc           = desc.hi.msg.tc;
        hdr_next.ido          = desc.hi.msg.attr[2];
        hdr_next.ro_ns        = desc.hi.msg.attr[1:0];
        hdr_next.length       = desc.hi.msg.dword_count[9:0];
        hdr_next.requester_id = desc.hi.msg.requester_id;
        hdr_next.tag          = desc.hi.msg.tag;
        hdr_next.be_code      = desc.hi.msg.msg_code;
        if (desc.kind == cq_rx_pkg::kind_vdm) begin
          // Destination ID, vendor ID, vendor DW
          hdr_next.dw23 = {desc.lo[15:0], desc.lo[31:16], desc.lo[63:32]};
        end else begin
          hdr_next.dw23 = desc.lo;                      // Upper DW first
        end
      end
    endcase
  end

  always_ff @(posedge user_clk or negedge user_reset_n) begin
    if (!user_reset_n) begin
      hdr_valid <= 1'b0;
    end else begin
      hdr_valid <= desc_valid;
    end
  end

  always_ff @(posedge user_clk) begin
    if (desc_valid) begin
      hdr <= hdr_next;
    end
  end

endmodule

// File: tb_cq_rx.sv
module tb_cq_rx;

  localparam int NUM_PKT     = 200;
  localparam int CYCLE_LIMIT = 40 * NUM_PKT + 200;
  localparam int DRIVE_DLY   = 1;                  // Input skew after the rising edge
  localparam int HDR_W       = $bits(cq_rx_pkg::tlp_hdr_t);
  localparam int CPL_W       = $bits(cq_rx_pkg::cpl_req_t);

  logic              user_clk;
  logic              user_reset_n;
  logic              link_up;
  logic [63:0]       cq_tdata;
  logic [40:0]       cq_tuser;
  logic [1:0]        cq_tkeep;
  logic              cq_tlast;
  logic              cq_tvalid;
  logic              cq_tready;
  logic              hdr_valid;
  logic [HDR_W-1:0]  hdr;
  logic              cpl_valid;
  logic [CPL_W-1:0]  cpl;

  integer            seed = 32'h14d4_a914;
  int                value_errors = 0;
  int                other_errors = 0;
  int                cycle_count = 0;
  logic [HDR_W-1:0]  hdr_q[$];                     // Expected headers in order
  logic [CPL_W-1:0]  cpl_q[$];                     // Expected completions of reads

  cq_rx_top u_cq_rx_top (
    .user_clk     (user_clk),
    .user_reset_n (user_reset_n),
    .link_up      (link_up),
    .cq_tdata     (cq_tdata),
    .cq_tuser     (cq_tuser),
    .cq_tkeep     (cq_tkeep),
    .cq_tlast     (cq_tlast),
    .cq_tvalid    (cq_tvalid),
    .cq_tready    (cq_tready),
    .hdr_valid    (hdr_valid),
    .hdr          (hdr),
    .cpl_valid    (cpl_valid),
    .cpl          (cpl)
  );

  always #2 user_clk = ~user_clk;

  always @(posedge user_clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [127:0] actual,
                             input logic [127:0] expected);
    if (actual !== expected) begin
      value_errors++;
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic logic [HDR_W-1:0] exp_header(input logic [3:0] code,
      input logic [63:0] lo, input logic [7:0] be, input logic [63:0] b1);
    logic [2:0]  fmt;
    logic [4:0]  typ;
    logic [7:0]  be_code;
    logic [63:0] dw23;
    logic [31:0] dw0;
    logic [31:0] dw1;
    if (code == cq_rx_pkg::REQ_MEM_RD || code == cq_rx_pkg::REQ_MEM_WR) begin
      fmt     = {1'b0, code == cq_rx_pkg::REQ_MEM_WR, lo[63:32] != 32'h0};
      typ     = 5'b00000;
      be_code = be;
      dw23    = (lo[63:32] == 32'h0) ? {lo[31:2], 2'b00, 32'h0} : {lo[63:2], 2'b00};
    end else begin
      fmt     = 3'b001;
      typ     = {2'b10, b1[50:48]};                // Routing from the message view
      be_code = b1[47:40];
      dw23    = (code == cq_rx_pkg::REQ_VDM) ? {lo[15:0], lo[31:16], lo[63:32]} : lo;
    end
    dw0 = {fmt, typ, 1'b0, b1[59:57], 1'b0, b1[62], 4'b0000, b1[61:60], 2'b00, b1[9:0]};
    dw1 = {b1[31:16], b1[39:32], be_code};
    return {dw0, dw1, dw23};
  endfunction

  function automatic logic [CPL_W-1:0] exp_cpl(input logic [63:0] lo,
      input logic [7:0] be, input logic [63:0] b1);
    int         i;
    int         lo_f;
    int         hi_f;
    int         hi_l;
    int         bc;
    logic [6:0] la;
    lo_f = 0;
    hi_f = 0;
    hi_l = 0;
    for (i = 3; i >= 0; i--) begin
      if (be[i]) lo_f = i;                         // Ends on the lowest set bit
    end
    for (i = 0; i < 4; i++) begin
      if (be[i]) hi_f = i;
      if (be[4 + i]) hi_l = i;
    end
    if (be[7:4] == 4'h0) begin
      bc = (be[3:0] == 4'h0) ? 1 : hi_f - lo_f + 1;
    end else begin
      bc = int'(b1[10:0]) * 4 - lo_f - (3 - hi_l);
    end
    la = (b1[10:0] == 11'h0) ? 7'h0 : {lo[6:2], 2'(lo_f)};
    return {b1[31:16], b1[39:32], b1[59:57], b1[62:60], b1[10:0], 12'(bc), la};
  endfunction

  // --------------------------------------------------------------------------
  // Output monitor sampling mid cycle
  // --------------------------------------------------------------------------
  always @(negedge user_clk) begin
    if (user_reset_n) begin
      if (cpl_valid && !hdr_valid) begin
        other_errors++;
        $display("Completion strobe arrived without its header strobe");
      end
      if (hdr_valid) begin
        if (hdr_q.size() == 0) begin
          other_errors++;
          $display("Header strobe arrived when no packet was expected");
        end else begin
          check_value("hdr.dw0_dw1", 128'(hdr[127:64]), 128'(hdr_q[0][127:64]));
          check_value("hdr.dw2_dw3", 128'(hdr[63:0]), 128'(hdr_q[0][63:0]));
          void'(hdr_q.pop_front());
        end
      end
      if (cpl_valid) begin
        if (cpl_q.size() == 0) begin
          other_errors++;
          $display("Completion strobe arrived when no memory read was expected");
        end else begin
          check_value("cpl", 128'(cpl), 128'(cpl_q[0]));
          void'(cpl_q.pop_front());
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  task automatic next_cycle();
    @(posedge user_clk);
    #DRIVE_DLY;
  endtask

  task automatic wait_ready();
    while (!cq_tready) next_cycle();
  endtask

  task automatic drive_beat(input logic [63:0] data, input logic [40:0] user,
                            input logic last);
    int unsigned gap;
    logic        accepted;
    gap = (rand_below(4) == 0) ? 1 + rand_below(2) : 0;
    cq_tvalid = 1'b0;
    repeat (gap) next_cycle();
    cq_tdata  = data;
    cq_tuser  = user;
    cq_tlast  = last;
    cq_tkeep  = 2'b11;
    cq_tvalid = 1'b1;
    accepted  = 1'b0;
    while (!accepted) begin
      accepted = cq_tready;                        // Ready holds until the next edge
      next_cycle();
    end
    cq_tvalid = 1'b0;
  endtask

  task automatic drop_link();
    cq_tvalid = 1'b0;
    link_up   = 1'b0;
    repeat (3 + rand_below(4)) next_cycle();
    link_up = 1'b1;
    wait_ready();
  endtask

  // ptype 0 read, 1 write, 2 message, 3 unsupported, 4 dropped before beat 1
  task automatic send_packet(input int ptype);
    logic [3:0]  code;
    logic [10:0] dwc;
    logic [7:0]  be;
    logic [63:0] lo;
    logic [63:0] b1;
    int unsigned npay;
    int unsigned k;
    npay = 0;
    dwc  = 11'(rand_below(65));
    lo   = {(rand_below(2) == 0) ? 32'h0 : 32'($random(seed)), 32'($random(seed))};
    be   = {(dwc <= 11'd1) ? 4'h0 : 4'($random(seed)), 4'($random(seed))};
    case (ptype)
      0, 4: code = cq_rx_pkg::REQ_MEM_RD;
      1: begin
        code = cq_rx_pkg::REQ_MEM_WR;
        npay = rand_below(7);
      end
      2: begin
        case (rand_below(3))
          0:       code = cq_rx_pkg::REQ_VDM;
          1:       code = cq_rx_pkg::REQ_ATS;
          default: code = cq_rx_pkg::REQ_MSG;
        endcase
        dwc  = 11'(rand_below(3));
        npay = rand_below(3);
      end
      default: begin
        do begin
          code = 4'($random(seed));
        end while (code == cq_rx_pkg::REQ_MEM_RD || code == cq_rx_pkg::REQ_MEM_WR ||
                   code == cq_rx_pkg::REQ_MSG || code == cq_rx_pkg::REQ_VDM ||
                   code == cq_rx_pkg::REQ_ATS);
        npay = rand_below(3);
      end
    endcase
    b1        = {32'($random(seed)), 32'($random(seed))};
    b1[63]    = 1'b0;
    b1[15]    = 1'b0;
    b1[14:11] = code;
    b1[10:0]  = dwc;
    drive_beat(lo, {1'b1, 32'h0, be}, 1'b0);
    if (ptype == 4) begin
      drop_link();                                 // Packet never completes
    end else begin
      if (ptype != 3) hdr_q.push_back(exp_header(code, lo, be, b1));
      if (ptype == 0) cpl_q.push_back(exp_cpl(lo, be, b1));
      drive_beat(b1, 41'h0, npay == 0);
      for (k = 0; k < npay; k++) begin
        drive_beat({32'($random(seed)), 32'($random(seed))}, 41'h0, k == npay - 1);
      end
    end
  endtask

  initial begin
    int i;
    user_clk     = 1'b0;
    user_reset_n = 1'b0;
    link_up      = 1'b0;
    cq_tdata     = '0;
    cq_tuser     = '0;
    cq_tkeep     = '0;
    cq_tlast     = 1'b0;
    cq_tvalid    = 1'b0;
    repeat (5) next_cycle();
    user_reset_n = 1'b1;

    // Nothing may move while the link is down
    repeat (8) begin
      next_cycle();
      check_value("cq_tready", 128'(cq_tready), '0);
      check_value("hdr_valid", 128'(hdr_valid), '0);
      check_value("cpl_valid", 128'(cpl_valid), '0);
    end
    link_up = 1'b1;
    repeat (3) next_cycle();
    if (!cq_tready) begin
      other_errors++;
      $display("tready did not rise after the link came up");
    end
    wait_ready();

    for (i = 0; i < NUM_PKT; i++) begin
      if (i < 60) send_packet(0);
      else if (i < 110) send_packet(1);
      else if (i < 140) send_packet(2);
      else if (i < 150) send_packet(3);
      else send_packet(int'(rand_below(5)));       // Mixed traffic with link drops
    end

    while (hdr_q.size() != 0 || cpl_q.size() != 0) next_cycle();
    repeat (10) next_cycle();                      // Catch any stray strobe

    $display("Errors: %0d value mismatches, %0d other failures",
             value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
cq_rx_pkg.sv
cq_rx_ctrl.sv
cq_tlp_hdr.sv
cpl_req_gen.sv
cq_rx_top.sv
tb_cq_rx.sv
